//--- common/mxint_pkg.sv
package mxint_pkg;

  // MXINT number format
  localparam int MAN_WIDTH = 8;  // Signed mantissa
  localparam int EXP_WIDTH = 4;  // Unsigned shared exponent
  localparam int LANES     = 4;  // 2x2 tile

  typedef logic signed [MAN_WIDTH-1:0] man_t;
  typedef logic [EXP_WIDTH-1:0] exp_t;

  // One block of mantissas sharing an exponent, 36 bits
  typedef struct packed {
    man_t [LANES-1:0] man;
    exp_t             exp;
  } mxint_block_t;

endpackage

//--- common/vit_attn_pkg.sv
package vit_attn_pkg;

  // Attention tensor geometry
  localparam int NUM_HEADS       = 4;
  localparam int TENSOR_DIM_0    = 16;                         // Elements per row
  localparam int IN_DATA_DEPTH   = TENSOR_DIM_0 / 2;           // Blocks per row
  localparam int BLOCKS_PER_HEAD = IN_DATA_DEPTH / NUM_HEADS;  // Blocks per head per row

  localparam int BLK_CNT_WIDTH  = $clog2(BLOCKS_PER_HEAD) + 1;  // Must hold BLOCKS_PER_HEAD
  localparam int HEAD_IDX_WIDTH = $clog2(NUM_HEADS);

  typedef logic [BLK_CNT_WIDTH-1:0] blk_cnt_t;
  typedef logic [HEAD_IDX_WIDTH-1:0] head_idx_t;

endpackage

//--- hdl/mxint_head_split.sv
`timescale 1ns/1ns

module mxint_head_split (
  input  logic                                clk,
  input  logic                                rst,

  input  mxint_pkg::mxint_block_t             in_block,
  input  logic                                in_valid,
  output logic                                in_ready,

  output mxint_pkg::mxint_block_t             head_block [vit_attn_pkg::NUM_HEADS],
  output logic [vit_attn_pkg::NUM_HEADS-1:0]  head_valid,
  input  logic [vit_attn_pkg::NUM_HEADS-1:0]  head_ready
);

  vit_attn_pkg::blk_cnt_t  blk_cnt;   // Block within the current head
  vit_attn_pkg::head_idx_t head_idx;  // Head that receives the next block
  logic                    xfer;
  logic                    last_blk;
  logic                    last_head;

  assign xfer      = in_valid && in_ready;
  assign last_blk  = blk_cnt == vit_attn_pkg::blk_cnt_t'(vit_attn_pkg::BLOCKS_PER_HEAD - 1);
  assign last_head = head_idx == vit_attn_pkg::head_idx_t'(vit_attn_pkg::NUM_HEADS - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      blk_cnt  <= '0;
      head_idx <= '0;
    end else if (xfer) begin
      if (last_blk) begin
        blk_cnt <= '0;
        if (last_head) begin
          head_idx <= '0;  // Next row starts at head 0
        end else begin
          head_idx <= head_idx + 1'b1;
        end
      end else begin
        blk_cnt <= blk_cnt + 1'b1;
      end
    end
  end

  // Payload goes to every head but only the indexed head sees valid
  always_comb begin
    for (int h = 0; h < vit_attn_pkg::NUM_HEADS; h++) begin
      head_block[h] = in_block;
      head_valid[h] = in_valid && (head_idx == vit_attn_pkg::head_idx_t'(h));
    end
  end

  assign in_ready = head_ready[head_idx];

  a_one_head_valid: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(head_valid)
  ) else $error("More than one head valid at once");

endmodule

//--- head_lane/mxint_block_normalize.sv
`timescale 1ns/1ns

module mxint_block_normalize (
  input  logic                    clk,
  input  logic                    rst,

  input  mxint_pkg::mxint_block_t in_block,
  input  logic                    in_valid,
  output logic                    in_ready,

  output mxint_pkg::mxint_block_t out_block,
  output logic                    out_valid,
  input  logic                    out_ready
);

  mxint_pkg::exp_t         lane_hr [mxint_pkg::LANES];  // Redundant sign bits per lane
  mxint_pkg::exp_t         min_hr;
  mxint_pkg::exp_t         shift;
  mxint_pkg::mxint_block_t norm_block;
  logic                    accept;

  // Leading bits equal to the sign bit, minus one
  function automatic mxint_pkg::exp_t headroom(input mxint_pkg::man_t m);
    mxint_pkg::exp_t cnt;
    logic            run;
    cnt = '0;
    run = 1'b1;
    if (m == '0) begin
      cnt = '1;  // Zero lane never limits the shift
    end else begin
      for (int i = mxint_pkg::MAN_WIDTH - 2; i >= 0; i--) begin
        if (run && (m[i] == m[mxint_pkg::MAN_WIDTH-1])) begin
          cnt = cnt + 1'b1;
        end else begin
          run = 1'b0;
        end
      end
    end
    return cnt;
  endfunction

  always_comb begin
    min_hr = '1;
    for (int l = 0; l < mxint_pkg::LANES; l++) begin
      lane_hr[l] = headroom(in_block.man[l]);
      if (lane_hr[l] < min_hr) begin
        min_hr = lane_hr[l];
      end
    end
    // Exponent cannot go below zero
    shift = (min_hr < in_block.exp) ? min_hr : in_block.exp;
    norm_block.exp = in_block.exp - shift;
    for (int l = 0; l < mxint_pkg::LANES; l++) begin
      norm_block.man[l] = in_block.man[l] << shift;
    end
  end

  assign in_ready = !out_valid || out_ready;  // Empty or draining this cycle
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_block <= norm_block;
    end
  end

  a_hold_when_stalled: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_block)
  ) else $error("Normalizer output changed while stalled");

endmodule

//--- head_lane/mxint_block_fifo.sv
`timescale 1ns/1ns

module mxint_block_fifo #(
  parameter int DEPTH = 4  // Power of two, 2 or more
) (
  input  logic                    clk,
  input  logic                    rst,

  input  mxint_pkg::mxint_block_t in_block,
  input  logic                    in_valid,
  output logic                    in_ready,

  output mxint_pkg::mxint_block_t out_block,
  output logic                    out_valid,
  input  logic                    out_ready
);

  mxint_pkg::mxint_block_t    mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH):0]     count;  // Fill level, 0 to DEPTH
  logic                       wr_en;
  logic                       rd_en;

  assign in_ready  = !count[$clog2(DEPTH)];  // MSB set only when full
  assign out_valid = |count;
  assign out_block = mem[rd_ptr];

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_block;
    end
  end

  // Overflow or underflow of the fill count would leave the range
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    count <= DEPTH
  ) else $error("FIFO written while full or read while empty");

  a_ptr_count_match: assert property (
    @(posedge clk) disable iff (rst)
    count[$clog2(DEPTH)-1:0] == (wr_ptr - rd_ptr)
  ) else $error("FIFO pointers disagree with fill count");

endmodule

//--- hdl/mxint_vit_attention_head_gather.sv
`timescale 1ns/1ns

module mxint_vit_attention_head_gather (
  input  logic                                clk,
  input  logic                                rst,

  input  mxint_pkg::mxint_block_t             head_block [vit_attn_pkg::NUM_HEADS],
  input  logic [vit_attn_pkg::NUM_HEADS-1:0]  head_valid,
  output logic [vit_attn_pkg::NUM_HEADS-1:0]  head_ready,

  output mxint_pkg::mxint_block_t             out_block,
  output logic                                out_valid,
  input  logic                                out_ready
);

  vit_attn_pkg::blk_cnt_t            blk_cnt [vit_attn_pkg::NUM_HEADS];
  logic [vit_attn_pkg::NUM_HEADS-1:0] done;  // Head has sent its share for this row
  logic [vit_attn_pkg::NUM_HEADS-1:0] xfer;
  logic                               all_done;
  vit_attn_pkg::head_idx_t            sel;

  assign all_done = &done;

  for (genvar h = 0; h < vit_attn_pkg::NUM_HEADS; h++) begin : g_cnt
    assign done[h] = blk_cnt[h] == vit_attn_pkg::blk_cnt_t'(vit_attn_pkg::BLOCKS_PER_HEAD);
    assign xfer[h] = head_valid[h] && head_ready[h];

    always_ff @(posedge clk) begin
      if (rst) begin
        blk_cnt[h] <= '0;
      end else if (all_done) begin
        // Head 0 may already send the first block of the next row
        blk_cnt[h] <= xfer[h] ? vit_attn_pkg::blk_cnt_t'(1) : '0;
      end else if (xfer[h]) begin
        blk_cnt[h] <= blk_cnt[h] + 1'b1;
      end
    end

    // Only an open head, or head 0 at the row wrap, may be drained
    a_ready_open_head: assert property (
      @(posedge clk) disable iff (rst)
      head_ready[h] |-> !done[h] || (all_done && h == 0)
    ) else $error("Ready given to a finished head");
  end

  // Lowest-numbered unfinished head or head 0 when all are finished
  always_comb begin
    sel = '0;
    for (int h = vit_attn_pkg::NUM_HEADS - 1; h >= 0; h--) begin
      if (!done[h]) begin
        sel = vit_attn_pkg::head_idx_t'(h);
      end
    end
  end

  assign out_block = head_block[sel];
  assign out_valid = head_valid[sel];

  always_comb begin
    for (int h = 0; h < vit_attn_pkg::NUM_HEADS; h++) begin
      head_ready[h] = out_ready && (sel == vit_attn_pkg::head_idx_t'(h));
    end
  end

endmodule

//--- hdl/mxint_head_regroup_top.sv
`timescale 1ns/1ns

module mxint_head_regroup_top (
  input  logic                    clk,
  input  logic                    rst,

  input  mxint_pkg::mxint_block_t in_block,
  input  logic                    in_valid,
  output logic                    in_ready,

  output mxint_pkg::mxint_block_t out_block,
  output logic                    out_valid,
  input  logic                    out_ready
);

  // Splitter to normalizers
  mxint_pkg::mxint_block_t            split_block [vit_attn_pkg::NUM_HEADS];
  logic [vit_attn_pkg::NUM_HEADS-1:0] split_valid;
  logic [vit_attn_pkg::NUM_HEADS-1:0] split_ready;

  // Normalizers to FIFOs
  mxint_pkg::mxint_block_t            norm_block [vit_attn_pkg::NUM_HEADS];
  logic [vit_attn_pkg::NUM_HEADS-1:0] norm_valid;
  logic [vit_attn_pkg::NUM_HEADS-1:0] norm_ready;

  // FIFOs to gather
  mxint_pkg::mxint_block_t            fifo_block [vit_attn_pkg::NUM_HEADS];
  logic [vit_attn_pkg::NUM_HEADS-1:0] fifo_valid;
  logic [vit_attn_pkg::NUM_HEADS-1:0] fifo_ready;

  mxint_head_split u_split (
    .clk        (clk),
    .rst        (rst),
    .in_block   (in_block),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .head_block (split_block),
    .head_valid (split_valid),
    .head_ready (split_ready)
  );

  for (genvar h = 0; h < vit_attn_pkg::NUM_HEADS; h++) begin : g_head
    mxint_block_normalize u_norm (
      .clk       (clk),
      .rst       (rst),
      .in_block  (split_block[h]),
      .in_valid  (split_valid[h]),
      .in_ready  (split_ready[h]),
      .out_block (norm_block[h]),
      .out_valid (norm_valid[h]),
      .out_ready (norm_ready[h])
    );

    mxint_block_fifo #(
      .DEPTH (4)
    ) u_fifo (
      .clk       (clk),
      .rst       (rst),
      .in_block  (norm_block[h]),
      .in_valid  (norm_valid[h]),
      .in_ready  (norm_ready[h]),
      .out_block (fifo_block[h]),
      .out_valid (fifo_valid[h]),
      .out_ready (fifo_ready[h])
    );
  end

  mxint_vit_attention_head_gather u_gather (
    .clk        (clk),
    .rst        (rst),
    .head_block (fifo_block),
    .head_valid (fifo_valid),
    .head_ready (fifo_ready),
    .out_block  (out_block),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

//--- sim/tb_mxint_head_regroup.sv
`timescale 1ns/1ns

module tb_mxint_head_regroup;

  localparam int MAX_VEC = 64;

  logic                    clk;
  logic                    rst;
  mxint_pkg::mxint_block_t in_block;
  logic                    in_valid;
  logic                    in_ready;
  mxint_pkg::mxint_block_t out_block;
  logic                    out_valid;
  logic                    out_ready;

  mxint_pkg::mxint_block_t vec_in  [MAX_VEC];
  mxint_pkg::mxint_block_t vec_exp [MAX_VEC];
  int                      vec_test [MAX_VEC];
  int                      num_vec;

  mxint_pkg::mxint_block_t exp_q [$];  // Expected output blocks in order
  int                      test_q [$];
  mxint_pkg::mxint_block_t exp_blk;
  int                      exp_test;
  int                      err_cnt [6];  // Per test number
  int                      stray_cnt;
  int                      recv_cnt;
  int                      pass_cnt;
  int                      fail_cnt;
  int                      cycle_cnt;
  int                      timeout_limit;
  int                      seed;

  mxint_head_regroup_top dut (
    .clk       (clk),
    .rst       (rst),
    .in_block  (in_block),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_block (out_block),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic load_vectors();
    int         fd;
    int         n;
    int         t;
    string      line;
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    logic [3:0] ae;
    logic [3:0] be;
    num_vec = 0;
    fd = $fopen("sim/head_regroup_vectors.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd) && num_vec < MAX_VEC) begin
      n = $fgets(line, fd);
      if (n > 0) begin
        n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h",
                    t, a0, a1, a2, a3, ae, b0, b1, b2, b3, be);
      end
      if (n == 11) begin  // Comment and blank lines fall through
        vec_test[num_vec] = t;
        vec_in[num_vec].man[0] = a0;
        vec_in[num_vec].man[1] = a1;
        vec_in[num_vec].man[2] = a2;
        vec_in[num_vec].man[3] = a3;
        vec_in[num_vec].exp = ae;
        vec_exp[num_vec].man[0] = b0;
        vec_exp[num_vec].man[1] = b1;
        vec_exp[num_vec].man[2] = b2;
        vec_exp[num_vec].man[3] = b3;
        vec_exp[num_vec].exp = be;
        num_vec++;
      end
    end
    $fclose(fd);
  endtask

  // Drives every vector once, with random gaps and output stalls if asked
  task automatic send_all(input logic random_mode);
    int   idx;
    logic accepted;
    idx = 0;
    accepted = 1'b0;
    while (idx < num_vec) begin
      @(negedge clk);
      if (random_mode) begin
        out_ready = $random(seed) & 1;
      end
      if (accepted || !in_valid) begin
        in_block = vec_in[idx];
        in_valid = random_mode ? (($random(seed) & 3) != 0) : 1'b1;
      end
      @(posedge clk);
      accepted = in_valid && in_ready;
      if (accepted) begin
        idx++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_outputs(input int target, input logic random_mode);
    while (recv_cnt < target) begin
      @(negedge clk);
      if (random_mode) begin
        out_ready = $random(seed) & 1;
      end
    end
    out_ready = 1'b1;
  endtask

  task automatic report_test(input int tnum, input string name);
    if (err_cnt[tnum] == 0) begin
      $display("Test %0d %s: pass", tnum, name);
      pass_cnt++;
    end else begin
      $display("Test %0d %s: FAIL with %0d errors", tnum, name, err_cnt[tnum]);
      fail_cnt++;
    end
  endtask

  // Output monitor checks each transfer against the next expected block
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected extra output block %h at time %0t", out_block, $time);
        stray_cnt++;
      end else begin
        exp_blk = exp_q.pop_front();
        exp_test = test_q.pop_front();
        if (out_block !== exp_blk) begin
          $display("Mismatch at time %0t: test %0d output %h, expected %h",
                   $time, exp_test, out_block, exp_blk);
          err_cnt[exp_test]++;
        end
        recv_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_limit) begin
      $display("Run timed out after %0d cycles with %0d output blocks missing",
               cycle_cnt, exp_q.size());
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    in_block = '0;
    in_valid = 1'b0;
    out_ready = 1'b1;
    seed = 70988;
    stray_cnt = 0;
    recv_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    cycle_cnt = 0;
    for (int i = 0; i < 6; i++) begin
      err_cnt[i] = 0;
    end
    load_vectors();
    timeout_limit = 64 * 2 * num_vec + 100;  // Each vector is driven twice
    if (num_vec == 0) begin
      $display("No vectors could be read from sim/head_regroup_vectors.txt");
      fail_cnt++;
    end else begin
      repeat (5) begin
        @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
          $display("Mismatch at time %0t: out_valid %b in_ready %b in reset, expected 0 1",
                   $time, out_valid, in_ready);
          err_cnt[1]++;
        end
      end
      rst = 1'b0;
      @(negedge clk);
      if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
        $display("Mismatch at time %0t: out_valid %b in_ready %b after reset, expected 0 1",
                 $time, out_valid, in_ready);
        err_cnt[1]++;
      end
      report_test(1, "reset");

      for (int i = 0; i < num_vec; i++) begin
        exp_q.push_back(vec_exp[i]);
        test_q.push_back(vec_test[i]);
      end
      send_all(1'b0);
      wait_outputs(num_vec, 1'b0);
      report_test(2, "normalization");
      report_test(3, "exponent floor and zero blocks");
      report_test(4, "split and gather order");

      for (int i = 0; i < num_vec; i++) begin
        exp_q.push_back(vec_exp[i]);
        test_q.push_back(5);
      end
      send_all(1'b1);
      wait_outputs(2 * num_vec, 1'b1);
      repeat (20) @(negedge clk);  // Catch late duplicates
      err_cnt[5] += stray_cnt;
      report_test(5, "back-pressure");
    end
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- sim/head_regroup_vectors.txt
# test, input mantissas 0 to 3, input exponent, expected mantissas 0 to 3, expected exponent
# All fields but the test number are hex
2 08 04 02 01 a 40 20 10 08 7
2 10 03 f0 05 a 40 0c c0 14 8
2 01 ff 02 fe a 20 e0 40 c0 5
2 7f 01 00 05 a 7f 01 00 05 a
2 f8 fc 04 03 9 80 c0 40 30 5
2 12 25 e5 0a 6 24 4a ca 14 5
2 e0 20 f0 10 c c0 40 e0 20 b
2 02 04 fc 08 f 10 20 e0 40 c
3 01 01 01 01 2 04 04 04 04 0
3 00 00 00 00 5 00 00 00 00 0
3 00 00 00 00 f 00 00 00 00 0
3 ff fe ff ff 3 f8 f0 f8 f8 0
3 02 00 00 00 4 20 00 00 00 0
3 03 fc 05 01 0 03 fc 05 01 0
3 00 00 00 00 0 00 00 00 00 0
3 08 f8 04 10 1 10 f0 08 20 0
4 11 22 33 44 8 11 22 33 44 8
4 01 02 03 04 7 10 20 30 40 3
4 f1 f2 f3 f4 8 88 90 98 a0 5
4 05 06 07 08 9 28 30 38 40 6
4 00 00 00 09 5 00 00 00 48 2
4 7f 80 40 c0 4 7f 80 40 c0 4
4 0c 0d 0e 0f 6 60 68 70 78 3
4 fa fb fc fd a a0 b0 c0 d0 6
4 18 19 1a 1b 3 60 64 68 6c 1
4 21 00 df 00 2 42 00 be 00 1
4 03 03 03 03 f 60 60 60 60 a
4 e8 17 0b f6 d a0 5c 2c d8 b
4 01 00 00 00 8 40 00 00 00 2
4 ff ff ff ff 8 80 80 80 80 1
4 35 ca 2b d4 5 6a 94 56 a8 4
4 06 f9 00 0e 1 0c f2 00 1c 0

//--- mxint_head_regroup.f
common/mxint_pkg.sv
common/vit_attn_pkg.sv
hdl/mxint_head_split.sv
head_lane/mxint_block_normalize.sv
head_lane/mxint_block_fifo.sv
hdl/mxint_vit_attention_head_gather.sv
hdl/mxint_head_regroup_top.sv
sim/tb_mxint_head_regroup.sv

//--- Bender.yml
package:
  name: mxint_head_regroup

sources:
  - files:
      - common/mxint_pkg.sv
      - common/vit_attn_pkg.sv
      - hdl/mxint_head_split.sv
      - head_lane/mxint_block_normalize.sv
      - head_lane/mxint_block_fifo.sv
      - hdl/mxint_vit_attention_head_gather.sv
      - hdl/mxint_head_regroup_top.sv
  - target: simulation
    files:
      - sim/tb_mxint_head_regroup.sv
